// ==== rtl/fp_fmt_pkg.sv ====
/*
 * number formats for the int-to-float converter
 * integer input width, single-precision fields and their width types
 */
`default_nettype none

package fp_fmt_pkg;

    // signed integer input
    localparam int INT_W = 32;

    // single-precision fields
    localparam int EXP_W    = 8;
    localparam int MAN_W    = 23;
    localparam int EXP_BIAS = 127;

    // leading-zero count covers positions 0..INT_W-1
    localparam int LZC_W = 5;

    // integer word, also used for the absolute value
    typedef logic [INT_W-1:0]         int_word_t;
    // sign, biased exponent and stored mantissa packed together
    typedef logic [1+EXP_W+MAN_W-1:0] fp32_t;
    typedef logic [EXP_W-1:0]         exp_t;
    typedef logic [MAN_W-1:0]         man_t;
    typedef logic [LZC_W-1:0]         lzc_t;

endpackage

`default_nettype wire

// ==== rtl/i2f_pipe_pkg.sv ====
/*
 * pipeline types for the int-to-float converter
 * holds the record passed from the magnitude stage to the normalize stage
 */
`default_nettype none

package i2f_pipe_pkg;

    import fp_fmt_pkg::*;

    // stage-one result
    typedef struct packed {
        // sign of the input integer
        logic      sign;
        // input was zero, mag and lzc carry no meaning then
        logic      zero;
        // absolute value, 2^31 for the most negative input
        int_word_t mag;
        // leading zeros above the top set bit of mag
        lzc_t      lzc;
    } mag_stage_t;

endpackage

`default_nettype wire

// ==== rtl/find_first_one.sv ====
/*
 * leading-one tree
 * index of the lowest set bit of in_i, plus a flag for an all-zero input
 */
`timescale 1ns/1ps
`default_nettype none

module find_first_one #(
    parameter int WIDTH = 32
) (
    input  wire logic [WIDTH-1:0]         in_i,
    output logic      [$clog2(WIDTH)-1:0] first_one_o,
    output logic                          no_ones_o
);

    // depth of the tree, also the index width
    localparam int LEVELS = $clog2(WIDTH);

    // node n has children 2n+1 and 2n+2, leaves start at 2**(LEVELS-1)-1
    logic [2**LEVELS-2:0]             node_hit;
    logic [2**LEVELS-2:0][LEVELS-1:0] node_idx;

    for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : g_level
        if (lvl == LEVELS-1) begin : g_leaf
            // leaves look at two neighbouring input bits
            for (genvar k = 0; k < 2**lvl; k++) begin : g_pair
                if (2*k+1 < WIDTH) begin : g_both
                    assign node_hit[2**lvl-1+k] = in_i[2*k] | in_i[2*k+1];
                    // lower bit wins
                    assign node_idx[2**lvl-1+k] = in_i[2*k] ? LEVELS'(2*k) : LEVELS'(2*k+1);
                end else if (2*k < WIDTH) begin : g_single
                    // odd width, last leaf has one bit
                    assign node_hit[2**lvl-1+k] = in_i[2*k];
                    assign node_idx[2**lvl-1+k] = LEVELS'(2*k);
                end else begin : g_none
                    // padding beyond the input
                    assign node_hit[2**lvl-1+k] = 1'b0;
                    assign node_idx[2**lvl-1+k] = '0;
                end
            end
        end else begin : g_inner
            // inner nodes merge two subtrees
            for (genvar k = 0; k < 2**lvl; k++) begin : g_node
                localparam int N  = 2**lvl-1+k;
                localparam int LO = 2**(lvl+1)-1+2*k;
                assign node_hit[N] = node_hit[LO] | node_hit[LO+1];
                // lower half has priority if it holds a one
                assign node_idx[N] = node_hit[LO] ? node_idx[LO] : node_idx[LO+1];
            end
        end
    end

    // root of the tree
    assign first_one_o = node_idx[0];
    assign no_ones_o   = ~node_hit[0];

endmodule

`default_nettype wire

// ==== rtl/i2f_ctrl.sv ====
/*
 * handshake control for the two-stage int-to-float pipeline
 * tracks stage occupancy and drives the stage load enables
 */
`timescale 1ns/1ps
`default_nettype none

module i2f_ctrl (
    input  wire logic clk_i,
    input  wire logic arst_n_i,
    input  wire logic in_valid_i,
    output logic      in_ready_o,
    input  wire logic out_ready_i,
    output logic      out_valid_o,
    output logic      s1_en_o,
    output logic      s2_en_o
);

    // occupancy of stage register and output register
    logic s1_valid_q;
    logic out_valid_q;
    // output register can take a new item this cycle
    logic s2_adv;

    assign s2_adv = ~out_valid_q | out_ready_i;

    // stage one takes input when empty or when it hands off to stage two
    assign in_ready_o = ~s1_valid_q | s2_adv;
    assign s1_en_o    = in_valid_i & in_ready_o;
    assign s2_en_o    = s1_valid_q & s2_adv;

    assign out_valid_o = out_valid_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_valid_q  <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            // a new item refills stage one even while the old one moves on
            if (s1_en_o) begin
                s1_valid_q <= 1'b1;
            end else if (s2_en_o) begin
                s1_valid_q <= 1'b0;
            end
            // output stays full until taken, unless refilled in the same cycle
            if (s2_en_o) begin
                out_valid_q <= 1'b1;
            end else if (out_ready_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    // a pending result is never withdrawn
    a_out_valid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o);

    // stage two only takes an item loaded last cycle or held over and not yet moved on
    a_s2_en_occupied: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        s2_en_o |-> $past(s1_en_o) || ($past(s1_valid_q) && !$past(s2_en_o)));

endmodule

`default_nettype wire

// ==== rtl/i2f_magnitude.sv ====
/*
 * stage one of the int-to-float pipeline
 * sign, absolute value and leading-zero count, registered on s1_en_i
 */
`timescale 1ns/1ps
`default_nettype none

module i2f_magnitude
    import fp_fmt_pkg::*;
    import i2f_pipe_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       arst_n_i,
    input  wire logic       s1_en_i,
    input  wire int_word_t  in_data_i,
    output mag_stage_t      stage_o
);

    int_word_t  mag;
    // magnitude with bit order flipped, msb at position 0
    int_word_t  mag_rev;
    lzc_t       lzc;
    logic       no_ones;
    mag_stage_t stage_d;
    mag_stage_t stage_q;

    // two's complement negate, -2^31 wraps to 2^31 as unsigned
    assign mag = in_data_i[INT_W-1] ? -in_data_i : in_data_i;

    always_comb begin
        for (int i = 0; i < INT_W; i++) begin
            mag_rev[i] = mag[INT_W-1-i];
        end
    end

    // lowest one of the reversed word is the leading one of mag
    find_first_one #(
        .WIDTH (INT_W)
    ) i_find_first_one (
        .in_i        (mag_rev),
        .first_one_o (lzc),
        .no_ones_o   (no_ones)
    );

    assign stage_d.sign = in_data_i[INT_W-1];
    assign stage_d.zero = no_ones;
    assign stage_d.mag  = mag;
    assign stage_d.lzc  = lzc;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stage_q <= '0;
        end else if (s1_en_i) begin
            stage_q <= stage_d;
        end
    end

    assign stage_o = stage_q;

endmodule

`default_nettype wire

// ==== rtl/i2f_normalize.sv ====
/*
 * stage two of the int-to-float pipeline
 * normalizes, rounds to nearest-even and packs the single-precision word
 */
`timescale 1ns/1ps
`default_nettype none

module i2f_normalize
    import fp_fmt_pkg::*;
    import i2f_pipe_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       arst_n_i,
    input  wire logic       s2_en_i,
    input  wire mag_stage_t stage_i,
    output fp32_t           out_data_o
);

    // magnitude with the leading one moved to the msb
    int_word_t      norm;
    man_t           man_trunc;
    // rounding bits below the kept mantissa
    logic           guard;
    logic           sticky;
    logic           round_up;
    // one extra bit catches the carry out of rounding
    logic [MAN_W:0] man_rnd;
    logic           man_carry;
    exp_t           exp_d;
    fp32_t          out_d;
    fp32_t          out_q;

    assign norm = stage_i.mag << stage_i.lzc;

    // hidden bit at INT_W-1 is dropped, next MAN_W bits are kept
    assign man_trunc = norm[INT_W-2 -: MAN_W];
    assign guard     = norm[INT_W-2-MAN_W];
    assign sticky    = |norm[INT_W-3-MAN_W:0];

    // nearest-even: above half rounds up, exact half only when lsb is odd
    assign round_up = guard & (sticky | man_trunc[0]);
    assign man_rnd  = {1'b0, man_trunc} + (MAN_W+1)'(round_up);

    // mantissa overflow leaves zeros below and bumps the exponent
    assign man_carry = man_rnd[MAN_W];

    // leading one at bit INT_W-1-lzc
    assign exp_d = exp_t'(EXP_BIAS + INT_W - 1) - exp_t'(stage_i.lzc)
                 + exp_t'(man_carry);

    always_comb begin
        if (stage_i.zero) begin
            // integer zero maps to +0
            out_d = '0;
        end else begin
            out_d = {stage_i.sign, exp_d, man_rnd[MAN_W-1:0]};
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_q <= '0;
        end else if (s2_en_i) begin
            out_q <= out_d;
        end
    end

    assign out_data_o = out_q;

    // largest magnitude is 2^31, so the registered exponent stays in range
    a_exp_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        s2_en_i && !stage_i.zero |=>
            out_data_o[MAN_W +: EXP_W] <= exp_t'(EXP_BIAS + INT_W - 1));

endmodule

`default_nettype wire

// ==== rtl/i2f_top.sv ====
/*
 * streaming int32 to single-precision converter
 * two pipeline stages behind valid/ready on both sides
 */
`timescale 1ns/1ps
`default_nettype none

module i2f_top
    import fp_fmt_pkg::*;
    import i2f_pipe_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,
    input  wire logic      in_valid_i,
    input  wire int_word_t in_data_i,
    output logic           in_ready_o,
    output logic           out_valid_o,
    output fp32_t          out_data_o,
    input  wire logic      out_ready_i
);

    // stage load enables
    logic       s1_en;
    logic       s2_en;
    // record between the stages
    mag_stage_t stage;

    i2f_ctrl i_i2f_ctrl (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .out_ready_i (out_ready_i),
        .out_valid_o (out_valid_o),
        .s1_en_o     (s1_en),
        .s2_en_o     (s2_en)
    );

    i2f_magnitude i_i2f_magnitude (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .s1_en_i   (s1_en),
        .in_data_i (in_data_i),
        .stage_o   (stage)
    );

    i2f_normalize i_i2f_normalize (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .s2_en_i    (s2_en),
        .stage_i    (stage),
        .out_data_o (out_data_o)
    );

endmodule

`default_nettype wire

// ==== tests/tb_i2f.sv ====
/*
 * testbench for the int32 to single-precision converter
 * directed and random stimulus checked against a reference model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_i2f
    import fp_fmt_pkg::*;
();

    localparam int N_DIR  = 14;
    localparam int N_FULL = 200;
    localparam int N_BP   = 400;
    // 20 cycles per item plus the reset time
    localparam int TIMEOUT_CYCLES = (N_DIR + N_FULL + N_BP + 2) * 20 + 10;

    logic        clk_i;
    logic        arst_n_i;
    logic        in_valid_i;
    int_word_t   in_data_i;
    logic        in_ready_o;
    logic        out_valid_o;
    fp32_t       out_data_o;
    logic        out_ready_i;

    // expected results, their inputs and acceptance cycles, oldest first
    fp32_t       exp_q[$];
    int_word_t   src_q[$];
    int          stamp_q[$];
    int          cycle;
    int          errors;
    int          in_count;
    int          out_count;
    // latency is fixed only while out_ready_i stays high
    logic        lat_check;
    logic        bp_on;
    // last cycle ended with a result waiting on out_ready_i
    logic        stall_prev;
    fp32_t       stall_data;
    logic [31:0] data_seed;
    logic [31:0] ready_seed;

    // zero, sign, exact powers, both ties, exponent carry
    int_word_t dir_vals [N_DIR] = '{
        32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0002,
        32'h0000_0400, 32'h0080_0000, 32'h0100_0000, 32'h4000_0000,
        32'hfff0_0000, 32'h0100_0001, 32'h0100_0003, 32'h7fff_ffff,
        32'h8000_0000, 32'hfeff_fffd
    };

    i2f_top i_i2f_top (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (in_valid_i),
        .in_data_i   (in_data_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .out_ready_i (out_ready_i)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // integer reference for the conversion
    function automatic fp32_t ref_convert(input int_word_t x);
        longint unsigned m;
        longint unsigned kept;
        longint unsigned rem;
        longint unsigned half;
        int              pos;
        int              sh;
        int              e;
        m = x[INT_W-1] ? 64'h1_0000_0000 - 64'(x) : 64'(x);
        if (m == 64'd0) begin
            return '0;
        end
        pos = 0;
        for (int i = 0; i < INT_W; i++) begin
            if (m[i]) begin
                pos = i;
            end
        end
        e = EXP_BIAS + pos;
        if (pos <= MAN_W) begin
            kept = m << (MAN_W - pos);
        end else begin
            // compare the dropped part against one half ulp
            sh   = pos - MAN_W;
            kept = m >> sh;
            rem  = m & ((64'd1 << sh) - 64'd1);
            half = 64'd1 << (sh - 1);
            if (rem > half || (rem == half && kept[0])) begin
                kept = kept + 64'd1;
            end
        end
        if (kept == (64'd1 << (MAN_W + 1))) begin
            kept = kept >> 1;
            e    = e + 1;
        end
        return {x[INT_W-1], exp_t'(e), kept[MAN_W-1:0]};
    endfunction

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // scoreboard, sampled at the rising edge
    always @(posedge clk_i) begin
        if (arst_n_i) begin
            cycle = cycle + 1;
            if (stall_prev && !out_valid_o) begin
                $display("out_valid_o dropped before the result was taken");
                errors = errors + 1;
            end else if (stall_prev && out_data_o != stall_data) begin
                $display("** Error: out_data_o = %h while stalled, expected %h",
                         out_data_o, stall_data);
                errors = errors + 1;
            end
            stall_prev = out_valid_o && !out_ready_i;
            stall_data = out_data_o;
            if (out_valid_o && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("a result left with no input pending");
                    errors = errors + 1;
                end else begin
                    if (out_data_o != exp_q[0]) begin
                        $display("** Error: out_data_o = %h, expected %h, input %h",
                                 out_data_o, exp_q[0], src_q[0]);
                        errors = errors + 1;
                    end
                    if (lat_check && cycle - stamp_q[0] != 2) begin
                        $display("result for input %h came %0d cycles after it, not 2",
                                 src_q[0], cycle - stamp_q[0]);
                        errors = errors + 1;
                    end
                    void'(exp_q.pop_front());
                    void'(src_q.pop_front());
                    void'(stamp_q.pop_front());
                end
                out_count = out_count + 1;
            end
            if (in_valid_i && in_ready_o) begin
                exp_q.push_back(ref_convert(in_data_i));
                src_q.push_back(in_data_i);
                stamp_q.push_back(cycle);
                in_count = in_count + 1;
            end
        end
    end

    // random back-pressure
    always @(negedge clk_i) begin
        if (bp_on) begin
            ready_seed  = lcg_step(ready_seed);
            out_ready_i = ready_seed[16];
        end
    end

    // idle for gap cycles, then offer d until it is taken
    task automatic send_item(input int_word_t d, input int gap);
        int start;
        start = in_count;
        if (gap > 0) begin
            in_valid_i = 1'b0;
            repeat (gap) @(negedge clk_i);
        end
        in_valid_i = 1'b1;
        in_data_i  = d;
        @(negedge clk_i);
        while (in_count == start) @(negedge clk_i);
    endtask

    // extra outputs end the wait too, the final count check reports them
    task automatic wait_drain();
        while (out_count < in_count) @(negedge clk_i);
    endtask

    initial begin
        in_valid_i  = 1'b0;
        in_data_i   = '0;
        out_ready_i = 1'b1;
        arst_n_i    = 1'b0;
        bp_on       = 1'b0;
        lat_check   = 1'b0;
        stall_prev  = 1'b0;
        stall_data  = '0;
        cycle       = 0;
        errors      = 0;
        in_count    = 0;
        out_count   = 0;
        data_seed   = 32'ha9c64496;
        // second stream so back-pressure does not disturb the data values
        ready_seed  = lcg_step(32'ha9c64496 ^ 32'h5bd1e995);
        repeat (10) @(negedge clk_i);
        arst_n_i = 1'b1;
        @(negedge clk_i);
        if (out_valid_o != 1'b0) begin
            $display("** Error: out_valid_o = %h after reset, expected 0", out_valid_o);
            errors = errors + 1;
        end
        if (in_ready_o != 1'b1) begin
            $display("** Error: in_ready_o = %h after reset, expected 1", in_ready_o);
            errors = errors + 1;
        end
        // directed values then random ones, back to back
        lat_check = 1'b1;
        foreach (dir_vals[i]) begin
            send_item(dir_vals[i], 0);
        end
        for (int i = 0; i < N_FULL; i++) begin
            data_seed = lcg_step(data_seed);
            send_item(data_seed, 0);
        end
        in_valid_i = 1'b0;
        wait_drain();
        lat_check = 1'b0;
        // random gaps on the input, random out_ready_i
        bp_on = 1'b1;
        for (int i = 0; i < N_BP; i++) begin
            data_seed = lcg_step(data_seed);
            in_data_i = data_seed;
            data_seed = lcg_step(data_seed);
            send_item(in_data_i, data_seed[31] ? 0 : int'(data_seed[30:29]));
        end
        in_valid_i  = 1'b0;
        bp_on       = 1'b0;
        out_ready_i = 1'b1;
        wait_drain();
        // park two items behind a blocked output
        out_ready_i = 1'b0;
        send_item(32'h1234_5678, 0);
        send_item(32'hfedc_ba98, 0);
        in_valid_i = 1'b0;
        repeat (3) @(negedge clk_i);
        if (in_ready_o != 1'b0) begin
            $display("** Error: in_ready_o = %h with both stages full, expected 0",
                     in_ready_o);
            errors = errors + 1;
        end
        out_ready_i = 1'b1;
        wait_drain();
        repeat (2) @(negedge clk_i);
        if (exp_q.size() != 0 || in_count != out_count) begin
            $display("%0d results still pending, %0d inputs and %0d outputs at the end",
                     exp_q.size(), in_count, out_count);
            errors = errors + 1;
        end
        $display("errors: %0d, inputs: %0d, outputs: %0d", errors, in_count, out_count);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/fp_fmt_pkg.sv
rtl/i2f_pipe_pkg.sv
rtl/find_first_one.sv
rtl/i2f_ctrl.sv
rtl/i2f_magnitude.sv
rtl/i2f_normalize.sv
rtl/i2f_top.sv
tests/tb_i2f.sv

// ==== run.sh ====
#!/bin/sh
# build and run the int-to-float testbench with Verilator
set -e

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module tb_i2f -Mdir obj_dir

./obj_dir/Vtb_i2f | tee sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
